/* Bender.yml */
package:
  name: uart_frame_parser

sources:
  # Packages first, the interfaces and modules use them
  - source/uart_proto_pkg.sv
  - source/parser_status_pkg.sv
  - source/field_if.sv
  - source/checked_if.sv
  - source/frame_sync.sv
  - source/crc8_check.sv
  - source/frame_assembler.sv
  - source/uart_frame_parser.sv
  - target: test
    files:
      - tb/tb_uart_frame_parser.sv

/* source/checked_if.sv */
`default_nettype none
`timescale 1ns/100ps

// Tagged frame bytes with the CRC verdict
interface checked_if;

    logic                   valid;
    logic                   ready;
    logic [7:0]             data;
    uart_proto_pkg::field_e field;
    logic                   last;
    logic                   crc_ok;     // Meaningful on the last beat only

    modport src (
        output valid, data, field, last, crc_ok,
        input  ready
    );

    modport dst (
        input  valid, data, field, last, crc_ok,
        output ready
    );

endinterface

`default_nettype wire

/* source/crc8_check.sv */
`default_nettype none
`timescale 1ns/100ps

// CRC-8 (poly 0x07, init 0x00, MSB first) over CMD, ADDR and DATA beats
module crc8_check (
    input  wire    clk,
    input  wire    rst,
    field_if.dst   in,
    checked_if.src out
);

    localparam logic [7:0] CRC_POLY = 8'h07;

    logic [7:0] crc_q;      // Running CRC of the frame so far
    logic       accept;

    // One byte through the bitwise shift register
    function automatic logic [7:0] crc8_next(input logic [7:0] crc, input logic [7:0] data);
        logic [7:0] c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    assign in.ready = !out.valid || out.ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q     <= 8'h00;
            out.valid <= 1'b0;
        end else begin
            if (accept) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end

            if (accept) begin
                if (in.last) begin
                    crc_q <= 8'h00;                     // Ready for the next frame
                end else begin
                    crc_q <= crc8_next(crc_q, in.data);
                end
            end
        end
    end

    // Beats pass through one stage later
    always_ff @(posedge clk) begin
        if (accept) begin
            out.data   <= in.data;
            out.field  <= in.field;
            out.last   <= in.last;
            out.crc_ok <= in.last && (in.data == crc_q);
        end
    end

endmodule

`default_nettype wire

/* source/field_if.sv */
`default_nettype none
`timescale 1ns/100ps

// Tagged frame bytes from the sync stage
interface field_if;

    logic                   valid;
    logic                   ready;
    logic [7:0]             data;
    uart_proto_pkg::field_e field;
    logic                   last;   // CRC byte of the frame

    modport src (
        output valid, data, field, last,
        input  ready
    );

    modport dst (
        input  valid, data, field, last,
        output ready
    );

endinterface

`default_nettype wire

/* source/frame_assembler.sv */
`default_nettype none
`timescale 1ns/100ps

// Collects fields, judges the frame and presents it on the output
module frame_assembler (
    input  wire                                          clk,
    input  wire                                          rst,
    checked_if.dst                                       in,
    output logic                                         frame_valid,
    input  wire                                          frame_ready,
    output uart_proto_pkg::cmd_u                         frame_cmd,
    output logic [31:0]                                  frame_addr,
    output logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] frame_data,
    output logic [parser_status_pkg::DATA_COUNT_W-1:0]   frame_count,
    output parser_status_pkg::status_e                   frame_status,
    output logic                                         soft_reset
);

    // Work buffer for the frame being collected
    uart_proto_pkg::cmd_u                          work_cmd;
    logic [31:0]                                   work_addr;
    logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] work_data;
    logic [parser_status_pkg::DATA_COUNT_W-1:0]    work_cnt;
    logic [1:0]                                    addr_idx;

    logic                       accept;
    logic                       last_beat;
    logic                       is_reset;
    logic                       good_reset;
    parser_status_pkg::status_e verdict;

    // Only the closing beat waits for the output slot
    assign in.ready   = !in.last || !frame_valid || frame_ready;
    assign accept     = in.valid && in.ready;
    assign last_beat  = accept && in.last;
    assign is_reset   = (work_cmd.raw == uart_proto_pkg::CMD_RESET);
    assign good_reset = is_reset && in.crc_ok;

    always_comb begin
        if (!is_reset && (work_cmd.f.size == uart_proto_pkg::SIZE_RSVD)) begin
            verdict = parser_status_pkg::ST_CMD_INV;
        end else if (!in.crc_ok) begin
            verdict = parser_status_pkg::ST_CRC_ERR;
        end else begin
            verdict = parser_status_pkg::ST_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_idx <= 2'd0;
            work_cnt <= '0;
        end else if (accept) begin
            case (in.field)
                uart_proto_pkg::FLD_CMD: begin
                    addr_idx <= 2'd0;
                    work_cnt <= '0;
                end
                uart_proto_pkg::FLD_ADDR: addr_idx <= addr_idx + 2'd1;
                uart_proto_pkg::FLD_DATA: work_cnt <= work_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (in.field)
                uart_proto_pkg::FLD_CMD: begin
                    work_cmd.raw <= in.data;
                    work_addr    <= '0;     // RESET frames report a zero address
                    work_data    <= '0;     // Unused bytes read as zero
                end
                uart_proto_pkg::FLD_ADDR: work_addr[{addr_idx, 3'b000} +: 8] <= in.data;
                uart_proto_pkg::FLD_DATA: work_data[{work_cnt[5:0], 3'b000} +: 8] <= in.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
            soft_reset  <= 1'b0;
        end else begin
            soft_reset <= last_beat && good_reset;
            if (last_beat && !good_reset) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // Output frame, loaded when the closing beat is judged
    always_ff @(posedge clk) begin
        if (last_beat && !good_reset) begin
            frame_cmd    <= work_cmd;
            frame_addr   <= work_addr;
            frame_data   <= work_data;
            frame_count  <= work_cnt;
            frame_status <= verdict;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        frame_valid && !frame_ready |=> frame_valid && $stable(frame_status)
            && $stable(frame_cmd) && $stable(frame_addr) && $stable(frame_data)
            && $stable(frame_count))
        else $error("frame_assembler: output frame dropped or changed before frame_ready");

    assert property (@(posedge clk) disable iff (rst) soft_reset |=> !soft_reset)
        else $error("frame_assembler: soft_reset longer than one cycle");

endmodule

`default_nettype wire

/* source/frame_sync.sv */
`default_nettype none
`timescale 1ns/100ps

// SOF hunt and field sequencer
module frame_sync (
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] rx_data,
    input  wire        rx_valid,
    output logic       rx_ready,
    field_if.src       out
);

    typedef enum logic [2:0] {
        S_HUNT,
        S_CMD,
        S_ADDR,
        S_DATA,
        S_CRC
    } state_t;

    state_t               state;
    logic                 rx_en;        // Holds rx_ready low right after reset
    logic [1:0]           addr_cnt;
    logic [6:0]           data_cnt;
    logic [6:0]           data_len;     // Data bytes expected in this frame
    logic [6:0]           beats;
    logic [6:0]           len_calc;
    logic                 accept;
    logic                 load;
    uart_proto_pkg::cmd_u cmd_in;

    assign rx_ready   = rx_en && (!out.valid || out.ready);
    assign accept     = rx_valid && rx_ready;
    assign load       = accept && (state != S_HUNT);   // SOF and garbage are dropped
    assign cmd_in.raw = rx_data;

    // Data length from the command byte
    always_comb begin
        beats = {3'b000, cmd_in.f.len} + 7'd1;
        if (cmd_in.f.rw) begin
            len_calc = 7'd0;
        end else begin
            case (cmd_in.f.size)
                uart_proto_pkg::SIZE_BYTE: len_calc = beats;
                uart_proto_pkg::SIZE_HALF: len_calc = beats << 1;
                uart_proto_pkg::SIZE_WORD: len_calc = beats << 2;
                default:                   len_calc = 7'd0;     // Reserved size
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_HUNT;
            rx_en     <= 1'b0;
            out.valid <= 1'b0;
            addr_cnt  <= 2'd0;
            data_cnt  <= 7'd0;
            data_len  <= 7'd0;
        end else begin
            rx_en <= 1'b1;
            if (load) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end

            if (accept) begin
                case (state)
                    S_HUNT: begin
                        if (rx_data == uart_proto_pkg::SOF_BYTE) state <= S_CMD;
                    end
                    S_CMD: begin
                        data_len <= len_calc;
                        addr_cnt <= 2'd0;
                        // RESET has no address field
                        state    <= (cmd_in.raw == uart_proto_pkg::CMD_RESET) ? S_CRC : S_ADDR;
                    end
                    S_ADDR: begin
                        addr_cnt <= addr_cnt + 2'd1;
                        data_cnt <= 7'd0;
                        if (addr_cnt == 2'd3) state <= (data_len == 7'd0) ? S_CRC : S_DATA;
                    end
                    S_DATA: begin
                        data_cnt <= data_cnt + 7'd1;
                        if (data_cnt + 7'd1 == data_len) state <= S_CRC;
                    end
                    default: state <= S_HUNT;   // CRC byte ends the frame
                endcase
            end
        end
    end

    // Output beat payload
    always_ff @(posedge clk) begin
        if (load) begin
            out.data <= rx_data;
            out.last <= (state == S_CRC);
            case (state)
                S_CMD:   out.field <= uart_proto_pkg::FLD_CMD;
                S_ADDR:  out.field <= uart_proto_pkg::FLD_ADDR;
                S_DATA:  out.field <= uart_proto_pkg::FLD_DATA;
                default: out.field <= uart_proto_pkg::FLD_CRC;
            endcase
        end
    end

    // A stalled beat must not move until the CRC stage takes it
    assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable(out.data)
            && $stable(out.field) && $stable(out.last))
        else $error("frame_sync: output beat changed while stalled");

endmodule

`default_nettype wire

/* source/parser_status_pkg.sv */
`default_nettype none

// Result side of the parser
package parser_status_pkg;

    // Status reported with every emitted frame
    typedef enum logic [7:0] {
        ST_OK      = 8'h00,
        ST_CRC_ERR = 8'h01,
        ST_CMD_INV = 8'h02     // Reserved SIZE, wins over a CRC error
    } status_e;

    // Largest data field, 16 word beats
    localparam int MAX_DATA_BYTES = 64;

    // Byte count 0 to 64
    localparam int DATA_COUNT_W = 7;

endpackage

`default_nettype wire

/* source/uart_frame_parser.sv */
`default_nettype none
`timescale 1ns/100ps

// Host-to-device frame parser, three byte stages
module uart_frame_parser (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire  [7:0]                                     rx_data,
    input  wire                                            rx_valid,
    output logic                                           rx_ready,
    output logic                                           frame_valid,
    input  wire                                            frame_ready,
    output uart_proto_pkg::cmd_u                           frame_cmd,
    output logic [31:0]                                    frame_addr,
    output logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] frame_data,
    output logic [parser_status_pkg::DATA_COUNT_W-1:0]     frame_count,
    output parser_status_pkg::status_e                     frame_status,
    output logic                                           soft_reset
);

    field_if   u_field_if ();       // Sync to CRC stage
    checked_if u_checked_if ();     // CRC stage to assembler

    frame_sync u_frame_sync (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .out      (u_field_if.src)
    );

    crc8_check u_crc8_check (
        .clk (clk),
        .rst (rst),
        .in  (u_field_if.dst),
        .out (u_checked_if.src)
    );

    frame_assembler u_frame_assembler (
        .clk          (clk),
        .rst          (rst),
        .in           (u_checked_if.dst),
        .frame_valid  (frame_valid),
        .frame_ready  (frame_ready),
        .frame_cmd    (frame_cmd),
        .frame_addr   (frame_addr),
        .frame_data   (frame_data),
        .frame_count  (frame_count),
        .frame_status (frame_status),
        .soft_reset   (soft_reset)
    );

endmodule

`default_nettype wire

/* source/uart_proto_pkg.sv */
`default_nettype none

// Wire format of the host-to-device frame
package uart_proto_pkg;

    localparam logic [7:0] SOF_BYTE  = 8'hA5;  // Start of frame, not covered by CRC
    localparam logic [7:0] CMD_RESET = 8'hFF;  // Frame is SOF, CMD, CRC only

    // Access size per beat
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_RSVD = 2'd3    // Reported as invalid command
    } size_e;

    // Command byte, MSB first
    typedef struct packed {
        logic       rw;     // 1 = read, no data bytes follow
        logic       inc;    // Address increment between beats
        size_e      size;
        logic [3:0] len;    // Beats minus one
    } cmd_fields_t;

    // Same command byte seen as opcode or as access descriptor
    typedef union packed {
        logic [7:0]  raw;
        cmd_fields_t f;
    } cmd_u;

    // Role of a forwarded byte inside the frame
    typedef enum logic [1:0] {
        FLD_CMD  = 2'd0,
        FLD_ADDR = 2'd1,
        FLD_DATA = 2'd2,
        FLD_CRC  = 2'd3
    } field_e;

endpackage

`default_nettype wire

/* tb.f */
source/uart_proto_pkg.sv
source/parser_status_pkg.sv
source/field_if.sv
source/checked_if.sv
source/frame_sync.sv
source/crc8_check.sv
source/frame_assembler.sv
source/uart_frame_parser.sv
tb/tb_uart_frame_parser.sv

/* tb/tb_uart_frame_parser.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_uart_frame_parser;

    localparam int     NUM_FRAMES   = 300;
    localparam int     RESET_CYCLES = 10;
    localparam int     CLK_PERIOD   = 10;
    localparam integer SEED         = 32'h7a71;
    // Worst case of 80 bytes per frame at 4 cycles each
    localparam longint TIMEOUT_NS   = longint'(NUM_FRAMES) * 80 * 4 * CLK_PERIOD
                                      + RESET_CYCLES * CLK_PERIOD;

    logic                                           clk;
    logic                                           rst;
    logic [7:0]                                     rx_data;
    logic                                           rx_valid;
    logic                                           rx_ready;
    logic                                           frame_valid;
    logic                                           frame_ready;
    uart_proto_pkg::cmd_u                           frame_cmd;
    logic [31:0]                                    frame_addr;
    logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] frame_data;
    logic [parser_status_pkg::DATA_COUNT_W-1:0]     frame_count;
    parser_status_pkg::status_e                     frame_status;
    logic                                           soft_reset;

    integer seed;
    integer ready_seed;     // Separate stream for the output back-pressure
    integer ready_r;
    int     stall_cnt;
    int     val_errs;
    int     proto_errs;
    int     frames_seen;
    int     resets_seen;

    // Expected results in frame order, one entry per frame in all queues
    bit                                             exp_soft_q[$];
    uart_proto_pkg::cmd_u                           exp_cmd_q[$];
    logic [31:0]                                    exp_addr_q[$];
    logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] exp_data_q[$];
    logic [parser_status_pkg::DATA_COUNT_W-1:0]     exp_count_q[$];
    parser_status_pkg::status_e                     exp_status_q[$];

    uart_frame_parser u_dut (
        .clk          (clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .frame_valid  (frame_valid),
        .frame_ready  (frame_ready),
        .frame_cmd    (frame_cmd),
        .frame_addr   (frame_addr),
        .frame_data   (frame_data),
        .frame_count  (frame_count),
        .frame_status (frame_status),
        .soft_reset   (soft_reset)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // CRC-8, poly 0x07, one bit at a time from the MSB
    function automatic logic [7:0] crc8_update(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ b[i];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    task automatic check_cmd(input uart_proto_pkg::cmd_u got, input uart_proto_pkg::cmd_u exp);
        if (got !== exp) begin
            val_errs++;
            $display("Error: %0t ns frame_cmd = 0x%02h, expected 0x%02h", $time, got.raw, exp.raw);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("Error: %0t ns frame_addr = 0x%08h, expected 0x%08h", $time, got, exp);
        end
    endtask

    task automatic check_data(input logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] got,
                              input logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("Error: %0t ns frame_data = 0x%0h, expected 0x%0h", $time, got, exp);
        end
    endtask

    task automatic check_count(input logic [parser_status_pkg::DATA_COUNT_W-1:0] got,
                               input logic [parser_status_pkg::DATA_COUNT_W-1:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("Error: %0t ns frame_count = %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_status(input parser_status_pkg::status_e got,
                                input parser_status_pkg::status_e exp);
        if (got !== exp) begin
            val_errs++;
            $display("Error: %0t ns frame_status = 0x%02h, expected 0x%02h", $time, got, exp);
        end
    endtask

    task automatic pop_expected();
        void'(exp_soft_q.pop_front());
        void'(exp_cmd_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_count_q.pop_front());
        void'(exp_status_q.pop_front());
    endtask

    // Called on a rising edge, returns on the edge that took the byte
    task automatic send_byte(input logic [7:0] b);
        integer r;
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clk);
        while (!rx_ready) @(posedge clk);
        r = $random(seed);
        if (r[3:0] > 4'd11) begin
            rx_valid <= 1'b0;
            repeat (r[6:4] + 1) @(posedge clk);
        end
    endtask

    task automatic gen_frame();
        integer                                         r;
        uart_proto_pkg::cmd_u                           cmd;
        logic [31:0]                                    addr;
        logic [parser_status_pkg::MAX_DATA_BYTES*8-1:0] data_exp;
        logic [7:0]                                     body[$];
        logic [7:0]                                     b;
        logic [7:0]                                     crc;
        bit                                             is_reset;
        bit                                             rsvd;
        bit                                             bad_crc;
        int                                             n_garbage;
        int                                             n_data;
        parser_status_pkg::status_e                     st;
        r         = $random(seed);
        n_garbage = int'(r[1:0]);
        for (int i = 0; i < n_garbage; i++) begin     // Garbage before SOF
            r = $random(seed);
            b = (r[7:0] == uart_proto_pkg::SOF_BYTE) ? 8'h5A : r[7:0];
            send_byte(b);
        end
        r        = $random(seed);
        is_reset = (r[2:0] == 3'd0);
        bad_crc  = (r[7:5] == 3'd0) || (is_reset && r[8]);
        addr     = $random(seed);
        cmd.raw  = addr[15:8] ^ addr[7:0];
        if (is_reset) begin
            cmd.raw = uart_proto_pkg::CMD_RESET;
        end else begin
            // Thin out reserved sizes to about one frame in eight
            if (cmd.f.size == uart_proto_pkg::SIZE_RSVD && r[3]) begin
                cmd.f.size = uart_proto_pkg::SIZE_WORD;
            end
            if (cmd.raw == uart_proto_pkg::CMD_RESET) cmd.raw = 8'h7F;
        end
        rsvd     = !is_reset && (cmd.f.size == uart_proto_pkg::SIZE_RSVD);
        n_data   = (cmd.f.rw || rsvd) ? 0 : (int'(cmd.f.len) + 1) << cmd.f.size;
        data_exp = '0;
        body.push_back(cmd.raw);
        if (!is_reset) begin
            for (int k = 0; k < 4; k++) body.push_back(addr[8*k +: 8]);
        end
        for (int k = 0; k < n_data; k++) begin
            r = $random(seed);
            data_exp[8*k +: 8] = r[7:0];
            body.push_back(r[7:0]);
        end
        crc = 8'h00;
        foreach (body[k]) crc = crc8_update(crc, body[k]);
        if (bad_crc) begin
            r   = $random(seed);
            crc = crc ^ {r[6:0], 1'b1};
        end
        if (rsvd) st = parser_status_pkg::ST_CMD_INV;
        else if (bad_crc) st = parser_status_pkg::ST_CRC_ERR;
        else st = parser_status_pkg::ST_OK;
        exp_soft_q.push_back(is_reset && !bad_crc);
        exp_cmd_q.push_back(cmd);
        exp_addr_q.push_back(is_reset ? 32'h0 : addr);
        exp_data_q.push_back(data_exp);
        exp_count_q.push_back(n_data[parser_status_pkg::DATA_COUNT_W-1:0]);
        exp_status_q.push_back(st);
        send_byte(uart_proto_pkg::SOF_BYTE);
        foreach (body[k]) send_byte(body[k]);
        send_byte(crc);
    endtask

    // Random back-pressure with an occasional long stall
    always @(posedge clk) begin
        ready_r = $random(ready_seed);
        if (stall_cnt > 0) begin
            stall_cnt   = stall_cnt - 1;
            frame_ready <= 1'b0;
        end else if (ready_r[9:0] == 10'd0) begin
            stall_cnt   = 50 + int'(ready_r[16:10]);
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= (ready_r[1:0] != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (soft_reset) begin
                if (exp_soft_q.size() == 0 || !exp_soft_q[0]) begin
                    proto_errs++;
                    $display("At %0t ns soft_reset pulsed but no good RESET frame was due", $time);
                end else begin
                    resets_seen++;
                    pop_expected();
                end
            end
            if (frame_valid && frame_ready) begin
                if (exp_soft_q.size() == 0) begin
                    proto_errs++;
                    $display("At %0t ns a frame came out but none was expected", $time);
                end else if (exp_soft_q[0]) begin
                    proto_errs++;
                    $display("At %0t ns a frame came out where a soft_reset was due", $time);
                    pop_expected();
                end else begin
                    check_cmd(frame_cmd, exp_cmd_q[0]);
                    check_addr(frame_addr, exp_addr_q[0]);
                    check_data(frame_data, exp_data_q[0]);
                    check_count(frame_count, exp_count_q[0]);
                    check_status(frame_status, exp_status_q[0]);
                    frames_seen++;
                    pop_expected();
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        frame_ready = 1'b0;
        seed        = SEED;
        ready_seed  = SEED ^ 32'h0000_ffff;
        stall_cnt   = 0;
        val_errs    = 0;
        proto_errs  = 0;
        frames_seen = 0;
        resets_seen = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < NUM_FRAMES; n++) gen_frame();
        rx_valid <= 1'b0;
        while (exp_soft_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);     // Catch any late extra output
        $display("Frames %0d, soft resets %0d, value errors %0d, protocol errors %0d",
                 frames_seen, resets_seen, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout at %0t ns with %0d results still outstanding", $time, exp_soft_q.size());
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
